// File: logic/matmul_pkg.sv
package matmul_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // One matrix element and one accumulator share this width
    localparam int data_width = 8;

    // Both operand memories and the result memory use the same address width
    localparam int addr_width = 10;
    localparam int stride_width = 8;

    // Wide enough for the longest run of a single tile
    localparam int count_width = 8;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [data_width-1:0] elem_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [stride_width-1:0] stride_t;
    typedef logic [count_width-1:0] count_t;

    // Run sequencing
    // idle waits for start, run covers fetch, compute and drain,
    // finished parks the FSM until start is dropped
    typedef enum logic [1:0] {
        idle     = 2'd0,
        run      = 2'd1,
        finished = 2'd2
    } seq_state_t;

endpackage

// File: logic/matmul_sequencer.sv
`timescale 1ns/10ps

module matmul_sequencer #(
    parameter int array_size  = 4,
    parameter int mac_latency = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    output matmul_pkg::seq_state_t state,
    output matmul_pkg::count_t     cycle_count,
    output logic                   done
);

    // Count at which done is high, 19 for a 4x4 mesh with a 3-stage MAC
    localparam matmul_pkg::count_t done_count =
        matmul_pkg::count_t'(3 * array_size - 1 + mac_latency + array_size + 1);

    matmul_pkg::seq_state_t state_next;
    logic                   last_col;

    // True in the cycle that carries the last column of C
    assign last_col = start && (state == matmul_pkg::run)
                      && (cycle_count == done_count - 1'b1);

    always_comb
    begin
        state_next = state;
        case (state)
            matmul_pkg::idle:
                if (start)
                    state_next = matmul_pkg::run;
            matmul_pkg::run:
                if (!start)
                    state_next = matmul_pkg::idle;
                else if (last_col)
                    state_next = matmul_pkg::finished;
            matmul_pkg::finished:
                if (!start)
                    state_next = matmul_pkg::idle;
            default:
                state_next = matmul_pkg::idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= matmul_pkg::idle;
            cycle_count <= '0;
            done <= 1'b0;
        end
        else
        begin
            state <= state_next;
            done <= last_col;
            // The count freezes once finished so the fetch window never reopens
            if (!start)
                cycle_count <= '0;
            else if (state != matmul_pkg::finished)
                cycle_count <= cycle_count + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (reset) done |-> state != matmul_pkg::idle)
        else $error("done is high while the sequencer is idle");

endmodule

// File: logic/operand_feeder.sv
`timescale 1ns/10ps

module operand_feeder #(
    parameter int array_size  = 4,
    parameter int mem_latency = 1
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         start,
    input  matmul_pkg::seq_state_t                       state,
    input  matmul_pkg::count_t                           cycle_count,
    input  matmul_pkg::addr_t                            base,
    input  matmul_pkg::stride_t                          stride,
    input  logic [array_size*matmul_pkg::data_width-1:0] mem_data,
    input  logic [array_size-1:0]                        lane_mask,
    input  logic [array_size-1:0]                        depth_mask,
    output matmul_pkg::addr_t                            mem_addr,
    output logic [array_size*matmul_pkg::data_width-1:0] skewed
);

    localparam int w = matmul_pkg::data_width;
    localparam int idx_width = (array_size > 1) ? $clog2(array_size) : 1;

    logic                   fetch_open;
    matmul_pkg::addr_t      step;
    logic [mem_latency:0]   issue_valid;
    logic [idx_width-1:0]   issue_idx [mem_latency+1];
    logic                   word_keep;

    assign step = matmul_pkg::addr_t'(stride);

    // Fetches happen on counts 0 to N-1 of a run and never after done
    assign fetch_open = start && (state != matmul_pkg::finished)
                        && (cycle_count < matmul_pkg::count_t'(array_size));

    ////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !fetch_open)
            mem_addr <= base - step;
        else if (cycle_count == '0)
            mem_addr <= base;
        else
            mem_addr <= mem_addr + step;
    end

    // Entry 0 follows the address onto the bus, the last entry meets the returning word
    always_ff @(posedge clk)
    begin
        if (reset || !start)
            issue_valid <= '0;
        else
            issue_valid <= {issue_valid[mem_latency-1:0], fetch_open};
    end

    always_ff @(posedge clk)
    begin
        issue_idx[0] <= cycle_count[idx_width-1:0];
        for (int s = 1; s <= mem_latency; s++)
            issue_idx[s] <= issue_idx[s-1];
    end

    // Words outside the window and masked depth indices count as zero
    assign word_keep = issue_valid[mem_latency] && depth_mask[issue_idx[mem_latency]];

    ////////////////////////////////////////
    // Lane masking and diagonal skew
    ////////////////////////////////////////

    for (genvar i = 0; i < array_size; i++)
    begin : g_lane
        matmul_pkg::elem_t masked;

        assign masked = (word_keep && lane_mask[i]) ? mem_data[i*w +: w] : '0;

        if (i == 0)
        begin : g_direct
            assign skewed[0 +: w] = masked;
        end
        else
        begin : g_delay
            matmul_pkg::elem_t stage [i];

            always_ff @(posedge clk)
            begin
                if (reset || !start)
                begin
                    for (int s = 0; s < i; s++)
                        stage[s] <= '0;
                end
                else
                begin
                    stage[0] <= masked;
                    for (int s = 1; s < i; s++)
                        stage[s] <= stage[s-1];
                end
            end

            assign skewed[i*w +: w] = stage[i-1];
        end
    end

    // Each fetch in the window lands k strides above the base
    assert property (@(posedge clk) disable iff (reset)
        fetch_open |=> mem_addr == $past(base) + $past(cycle_count) * $past(step))
        else $error("operand address left the base plus k times stride sequence");

endmodule

// File: logic/processing_element.sv
`timescale 1ns/10ps

module processing_element #(
    parameter int mac_latency = 3
) (
    input  logic              clk,
    input  logic              clear,
    input  matmul_pkg::elem_t in_a,
    input  matmul_pkg::elem_t in_b,
    output matmul_pkg::elem_t out_a,
    output matmul_pkg::elem_t out_b,
    output matmul_pkg::elem_t acc
);

    // Product stages between the operands and the accumulator
    localparam int prod_stages = mac_latency - 1;

    matmul_pkg::elem_t product [prod_stages];

    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            out_a <= '0;
            out_b <= '0;
            for (int p = 0; p < prod_stages; p++)
                product[p] <= '0;
            acc <= '0;
        end
        else
        begin
            // Operands move on to the right and downward neighbours
            out_a <= in_a;
            out_b <= in_b;

            // Only the low byte of the product matters for a wrapping accumulator
            product[0] <= in_a * in_b;
            for (int p = 1; p < prod_stages; p++)
                product[p] <= product[p-1];

            acc <= acc + product[prod_stages-1];
        end
    end

endmodule

// File: logic/pe_array.sv
`timescale 1ns/10ps

module pe_array #(
    parameter int array_size  = 4,
    parameter int mac_latency = 3
) (
    input  logic                                                    clk,
    input  logic                                                    start,
    input  logic [array_size*matmul_pkg::data_width-1:0]            a_lanes,
    input  logic [array_size*matmul_pkg::data_width-1:0]            b_lanes,
    output logic [array_size*array_size*matmul_pkg::data_width-1:0] acc_matrix
);

    localparam int w = matmul_pkg::data_width;

    logic clear;

    // a_link[r][c] enters node (r, c) from the left
    // b_link[r][c] enters it from above
    matmul_pkg::elem_t a_link [array_size][array_size+1];
    matmul_pkg::elem_t b_link [array_size+1][array_size];

    // The mesh starts every run from zero
    assign clear = !start;

    ////////////////////////////////////////
    // Mesh edges
    ////////////////////////////////////////

    for (genvar r = 0; r < array_size; r++)
    begin : g_west
        assign a_link[r][0] = a_lanes[r*w +: w];
    end

    for (genvar c = 0; c < array_size; c++)
    begin : g_north
        assign b_link[0][c] = b_lanes[c*w +: w];
    end

    ////////////////////////////////////////
    // Nodes
    ////////////////////////////////////////

    for (genvar r = 0; r < array_size; r++)
    begin : g_row
        for (genvar c = 0; c < array_size; c++)
        begin : g_col
            processing_element #(
                .mac_latency (mac_latency)
            ) pe_inst (
                .clk   (clk),
                .clear (clear),
                .in_a  (a_link[r][c]),
                .in_b  (b_link[r][c]),
                .out_a (a_link[r][c+1]),
                .out_b (b_link[r+1][c]),
                .acc   (acc_matrix[(r*array_size+c)*w +: w])
            );
        end
    end

endmodule

// File: logic/result_drain.sv
`timescale 1ns/10ps

module result_drain #(
    parameter int array_size  = 4,
    parameter int mac_latency = 3
) (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    start,
    input  matmul_pkg::count_t                                      cycle_count,
    input  logic [array_size*array_size*matmul_pkg::data_width-1:0] acc_matrix,
    input  matmul_pkg::addr_t                                       address_mat_c,
    input  matmul_pkg::stride_t                                     address_stride_c,
    output logic [array_size*matmul_pkg::data_width-1:0]            c_data,
    output matmul_pkg::addr_t                                       c_addr,
    output logic                                                    c_data_available
);

    localparam int w = matmul_pkg::data_width;
    localparam int bus_width = array_size * w;

    // First count at which every accumulator holds its final sum
    localparam matmul_pkg::count_t latch_count =
        matmul_pkg::count_t'(3 * array_size - 1 + mac_latency);

    logic [bus_width-1:0] column [array_size];
    logic [bus_width-1:0] col_q [array_size-1];
    logic                 latch;
    matmul_pkg::count_t   cols_left;

    assign latch = start && (cycle_count == latch_count);

    // Column k gathers C[i][k] of every row, lane i in bits i*w upward
    for (genvar k = 0; k < array_size; k++)
    begin : g_column
        for (genvar i = 0; i < array_size; i++)
        begin : g_elem
            assign column[k][i*w +: w] = acc_matrix[(i*array_size+k)*w +: w];
        end
    end

    ////////////////////////////////////////
    // Output sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start)
        begin
            c_data <= '0;
            c_data_available <= 1'b0;
            cols_left <= '0;
            c_addr <= address_mat_c;
        end
        else if (latch)
        begin
            c_data <= column[0];
            c_data_available <= 1'b1;
            cols_left <= matmul_pkg::count_t'(array_size - 1);
            c_addr <= address_mat_c;
        end
        else if (cols_left != '0)
        begin
            c_data <= col_q[0];
            cols_left <= cols_left - 1'b1;
            c_addr <= c_addr + matmul_pkg::addr_t'(address_stride_c);
        end
        else
        begin
            c_data <= '0;
            c_data_available <= 1'b0;
        end
    end

    // Columns 1 to N-1 wait here and move one place per cycle
    always_ff @(posedge clk)
    begin
        if (latch)
        begin
            for (int k = 0; k < array_size - 1; k++)
                col_q[k] <= column[k+1];
        end
        else
        begin
            for (int k = 0; k < array_size - 2; k++)
                col_q[k] <= col_q[k+1];
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        c_data_available [*array_size] |=> !c_data_available)
        else $error("c_data_available stayed high for more than one matrix");

endmodule

// File: logic/matmul_top.sv
`timescale 1ns/10ps

module matmul_top #(
    parameter int array_size  = 4,
    parameter int mac_latency = 3,
    parameter int mem_latency = 1
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         start,
    input  matmul_pkg::addr_t                            address_mat_a,
    input  matmul_pkg::addr_t                            address_mat_b,
    input  matmul_pkg::addr_t                            address_mat_c,
    input  matmul_pkg::stride_t                          address_stride_a,
    input  matmul_pkg::stride_t                          address_stride_b,
    input  matmul_pkg::stride_t                          address_stride_c,
    input  logic [array_size*matmul_pkg::data_width-1:0] a_data,
    input  logic [array_size*matmul_pkg::data_width-1:0] b_data,
    input  logic [array_size-1:0]                        validity_mask_a_rows,
    input  logic [array_size-1:0]                        validity_mask_a_cols_b_rows,
    input  logic [array_size-1:0]                        validity_mask_b_cols,
    output matmul_pkg::addr_t                            a_addr,
    output matmul_pkg::addr_t                            b_addr,
    output matmul_pkg::addr_t                            c_addr,
    output logic [array_size*matmul_pkg::data_width-1:0] c_data,
    output logic                                         c_data_available,
    output logic                                         done
);

    localparam int bus_width = array_size * matmul_pkg::data_width;

    matmul_pkg::seq_state_t                state;
    matmul_pkg::count_t                    cycle_count;
    logic [bus_width-1:0]                  a_skewed;
    logic [bus_width-1:0]                  b_skewed;
    logic [array_size*bus_width-1:0]       acc_matrix;

    matmul_sequencer #(
        .array_size  (array_size),
        .mac_latency (mac_latency)
    ) sequencer (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .state       (state),
        .cycle_count (cycle_count),
        .done        (done)
    );

    ////////////////////////////////////////
    // Operand paths
    ////////////////////////////////////////

    // A words are columns of A, so the row mask selects lanes
    operand_feeder #(
        .array_size  (array_size),
        .mem_latency (mem_latency)
    ) a_feeder (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .state       (state),
        .cycle_count (cycle_count),
        .base        (address_mat_a),
        .stride      (address_stride_a),
        .mem_data    (a_data),
        .lane_mask   (validity_mask_a_rows),
        .depth_mask  (validity_mask_a_cols_b_rows),
        .mem_addr    (a_addr),
        .skewed      (a_skewed)
    );

    // B words are rows of B, so the column mask selects lanes
    operand_feeder #(
        .array_size  (array_size),
        .mem_latency (mem_latency)
    ) b_feeder (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .state       (state),
        .cycle_count (cycle_count),
        .base        (address_mat_b),
        .stride      (address_stride_b),
        .mem_data    (b_data),
        .lane_mask   (validity_mask_b_cols),
        .depth_mask  (validity_mask_a_cols_b_rows),
        .mem_addr    (b_addr),
        .skewed      (b_skewed)
    );

    pe_array #(
        .array_size  (array_size),
        .mac_latency (mac_latency)
    ) mesh (
        .clk        (clk),
        .start      (start),
        .a_lanes    (a_skewed),
        .b_lanes    (b_skewed),
        .acc_matrix (acc_matrix)
    );

    result_drain #(
        .array_size  (array_size),
        .mac_latency (mac_latency)
    ) drain (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .cycle_count      (cycle_count),
        .acc_matrix       (acc_matrix),
        .address_mat_c    (address_mat_c),
        .address_stride_c (address_stride_c),
        .c_data           (c_data),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

// File: test/matmul_tb.sv
`timescale 1ns/10ps

module matmul_tb;

    localparam int n = 4;
    localparam int mac_latency = 3;
    localparam int w = matmul_pkg::data_width;
    localparam int num_runs = 6;

    // Run timing in cycles counted from the first rising edge with start high
    localparam int latch_cycle = 3 * n - 1 + mac_latency;
    localparam int done_cycle = latch_cycle + n + 1;

    logic                clk;
    logic                reset;
    logic                start;
    matmul_pkg::addr_t   address_mat_a;
    matmul_pkg::addr_t   address_mat_b;
    matmul_pkg::addr_t   address_mat_c;
    matmul_pkg::stride_t address_stride_a;
    matmul_pkg::stride_t address_stride_b;
    matmul_pkg::stride_t address_stride_c;
    logic [n*w-1:0]      a_data;
    logic [n*w-1:0]      b_data;
    logic [n-1:0]        validity_mask_a_rows;
    logic [n-1:0]        validity_mask_a_cols_b_rows;
    logic [n-1:0]        validity_mask_b_cols;
    matmul_pkg::addr_t   a_addr;
    matmul_pkg::addr_t   b_addr;
    matmul_pkg::addr_t   c_addr;
    logic [n*w-1:0]      c_data;
    logic                c_data_available;
    logic                done;

    logic [n*w-1:0]      mem_a [1024];
    logic [n*w-1:0]      mem_b [1024];
    matmul_pkg::addr_t   a_pending;
    matmul_pkg::addr_t   b_pending;
    logic [n*w-1:0]      exp_col [n];
    int                  errors;
    int                  run_cycle;
    int                  col_idx;
    int                  done_seen;
    logic                prev_start;

    matmul_top #(
        .array_size  (n),
        .mac_latency (mac_latency),
        .mem_latency (1)
    ) matmul_top_inst (
        .clk                         (clk),
        .reset                       (reset),
        .start                       (start),
        .address_mat_a               (address_mat_a),
        .address_mat_b               (address_mat_b),
        .address_mat_c               (address_mat_c),
        .address_stride_a            (address_stride_a),
        .address_stride_b            (address_stride_b),
        .address_stride_c            (address_stride_c),
        .a_data                      (a_data),
        .b_data                      (b_data),
        .validity_mask_a_rows        (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows (validity_mask_a_cols_b_rows),
        .validity_mask_b_cols        (validity_mask_b_cols),
        .a_addr                      (a_addr),
        .b_addr                      (b_addr),
        .c_addr                      (c_addr),
        .c_data                      (c_data),
        .c_data_available            (c_data_available),
        .done                        (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        repeat (num_runs * 40 + 100) @(posedge clk);
        $display("Timeout: the DUT did not finish all runs in time");
        $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////

    // The address seen at one falling edge returns its word at the next one
    always @(negedge clk)
    begin
        a_data <= mem_a[a_pending];
        b_data <= mem_b[b_pending];
        a_pending <= a_addr;
        b_pending <= b_addr;
    end

    function automatic matmul_pkg::addr_t element_addr(input matmul_pkg::addr_t base,
                                                       input matmul_pkg::stride_t stride,
                                                       input int k);
        return base + matmul_pkg::addr_t'(k) * matmul_pkg::addr_t'(stride);
    endfunction

    function automatic matmul_pkg::elem_t random_elem(input bit near_max);
        if (near_max)
            return matmul_pkg::elem_t'(240 + $urandom_range(15));
        return matmul_pkg::elem_t'($urandom);
    endfunction

    // C[i][j] is the wrapping sum of A[i][k] times B[k][j] with masked elements as zero
    task automatic compute_reference();
        matmul_pkg::elem_t sum;
        matmul_pkg::elem_t a_elem;
        matmul_pkg::elem_t b_elem;
        for (int j = 0; j < n; j++)
        begin
            for (int i = 0; i < n; i++)
            begin
                sum = '0;
                for (int k = 0; k < n; k++)
                begin
                    a_elem = mem_a[element_addr(address_mat_a, address_stride_a, k)][i*w +: w];
                    b_elem = mem_b[element_addr(address_mat_b, address_stride_b, k)][j*w +: w];
                    if (!validity_mask_a_rows[i] || !validity_mask_a_cols_b_rows[k])
                        a_elem = '0;
                    if (!validity_mask_a_cols_b_rows[k] || !validity_mask_b_cols[j])
                        b_elem = '0;
                    sum = sum + matmul_pkg::elem_t'(a_elem * b_elem);
                end
                exp_col[j][i*w +: w] = sum;
            end
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Called on a falling edge and returns on a falling edge with start low
    task automatic run_matmul(input matmul_pkg::addr_t base_a, input matmul_pkg::addr_t base_b,
                              input matmul_pkg::addr_t base_c, input matmul_pkg::stride_t stride_a,
                              input matmul_pkg::stride_t stride_b,
                              input matmul_pkg::stride_t stride_c,
                              input logic [n-1:0] mask_rows, input logic [n-1:0] mask_shared,
                              input logic [n-1:0] mask_cols, input bit near_max, input int gap);
        address_mat_a = base_a;
        address_mat_b = base_b;
        address_mat_c = base_c;
        address_stride_a = stride_a;
        address_stride_b = stride_b;
        address_stride_c = stride_c;
        validity_mask_a_rows = mask_rows;
        validity_mask_a_cols_b_rows = mask_shared;
        validity_mask_b_cols = mask_cols;
        for (int k = 0; k < n; k++)
        begin
            for (int i = 0; i < n; i++)
            begin
                mem_a[element_addr(base_a, stride_a, k)][i*w +: w] = random_elem(near_max);
                mem_b[element_addr(base_b, stride_b, k)][i*w +: w] = random_elem(near_max);
            end
        end
        compute_reference();
        @(negedge clk);
        start = 1'b1;
        while (!done)
            @(negedge clk);
        // Hold start a little longer so the finished state is seen
        repeat (3) @(negedge clk);
        start = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    initial
    begin
        void'($urandom(32'h2fdc6d8d));
        errors = 0;
        reset = 1'b1;
        start = 1'b0;
        address_mat_a = '0;
        address_mat_b = '0;
        address_mat_c = '0;
        address_stride_a = '0;
        address_stride_b = '0;
        address_stride_c = '0;
        validity_mask_a_rows = '0;
        validity_mask_a_cols_b_rows = '0;
        validity_mask_b_cols = '0;
        a_data = '0;
        b_data = '0;
        a_pending = '0;
        b_pending = '0;
        for (int addr = 0; addr < 1024; addr++)
        begin
            mem_a[addr] = $urandom;
            mem_b[addr] = $urandom;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        run_matmul(10'h000, 10'h100, 10'h200, 8'd1, 8'd1, 8'd1, 4'hf, 4'hf, 4'hf, 1'b0, 2);
        // Second stride set with bases close enough to the top that addresses wrap
        run_matmul(10'h3f0, 10'h2c5, 10'h3fe, 8'd37, 8'd200, 8'd9, 4'hf, 4'hf, 4'hf, 1'b0, 2);
        run_matmul(10'h040, 10'h080, 10'h0c0, 8'd3, 8'd5, 8'd7, 4'($urandom_range(15)),
                   4'($urandom_range(15)), 4'($urandom_range(15)), 1'b0, 2);
        run_matmul(10'h123, 10'h234, 10'h345, 8'd11, 8'd13, 8'd2, 4'($urandom_range(15)),
                   4'($urandom_range(15)), 4'($urandom_range(15)), 1'b0, 2);
        run_matmul(10'h010, 10'h020, 10'h030, 8'd1, 8'd2, 8'd3, 4'hf, 4'hf, 4'hf, 1'b1, 0);
        // Back to back with one low cycle between runs
        run_matmul(10'h300, 10'h310, 10'h320, 8'd4, 8'd4, 8'd4, 4'hf, 4'hf, 4'hf, 1'b0, 3);

        $display("Run finished with %0d errors", errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_fetch_addr(input string name, input matmul_pkg::addr_t actual,
                                    input matmul_pkg::addr_t base,
                                    input matmul_pkg::stride_t stride);
        matmul_pkg::addr_t expected;
        if (run_cycle >= 1 && run_cycle <= n)
            expected = element_addr(base, stride, run_cycle - 1);
        else
            expected = base - matmul_pkg::addr_t'(stride);
        assert (actual == expected)
        else
        begin
            errors++;
            $display("Mismatch %s at cycle %0d: expected %h actual %h",
                     name, run_cycle, expected, actual);
        end
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            run_cycle = 0;
            col_idx = 0;
            done_seen = 0;
        end
        else if (start)
        begin
            check_fetch_addr("a_addr", a_addr, address_mat_a, address_stride_a);
            check_fetch_addr("b_addr", b_addr, address_mat_b, address_stride_b);
            assert (c_data_available == (run_cycle > latch_cycle && run_cycle <= latch_cycle + n))
            else
            begin
                errors++;
                $display("Mismatch c_data_available at cycle %0d: expected %h actual %h",
                         run_cycle, run_cycle > latch_cycle && run_cycle <= latch_cycle + n,
                         c_data_available);
            end
            if (c_data_available && col_idx < n)
            begin
                assert (c_data == exp_col[col_idx])
                else
                begin
                    errors++;
                    $display("Mismatch c_data column %0d: expected %h actual %h",
                             col_idx, exp_col[col_idx], c_data);
                end
                assert (c_addr == element_addr(address_mat_c, address_stride_c, col_idx))
                else
                begin
                    errors++;
                    $display("Mismatch c_addr column %0d: expected %h actual %h", col_idx,
                             element_addr(address_mat_c, address_stride_c, col_idx), c_addr);
                end
                col_idx++;
            end
            assert (done == (run_cycle == done_cycle))
            else
            begin
                errors++;
                $display("Mismatch done at cycle %0d: expected %h actual %h",
                         run_cycle, run_cycle == done_cycle, done);
            end
            if (done)
                done_seen++;
            run_cycle++;
        end
        else if (prev_start)
        begin
            assert (col_idx == n && done_seen == 1)
            else
            begin
                errors++;
                $display("A run ended with %0d columns and %0d done pulses", col_idx, done_seen);
            end
            run_cycle = 0;
            col_idx = 0;
            done_seen = 0;
        end
        prev_start = start;
    end

    // One cycle after start is low every output is quiet
    assert property (@(posedge clk) disable iff (reset)
        !start |=> !done && !c_data_available && c_data == '0)
        else
        begin
            errors++;
            $display("Outputs were still active while start was low");
        end

    assert property (@(posedge clk) disable iff (reset)
        done |-> $past(c_data_available) && !c_data_available)
        else
        begin
            errors++;
            $display("done did not follow the last result column");
        end

endmodule

// File: src.f
logic/matmul_pkg.sv
logic/matmul_sequencer.sv
logic/operand_feeder.sv
logic/processing_element.sv
logic/pe_array.sv
logic/result_drain.sv
logic/matmul_top.sv
test/matmul_tb.sv
